// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_control_unit
FILELIST  ?= filelist.f
LOG       ?= sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
hdl/cu_pkg.sv
hdl/instr_decoder.sv
hdl/cu_sequencer.sv
hdl/ctrl_encoder.sv
hdl/control_unit.sv
tb/control_unit_chk.sv
tb/tb_control_unit.sv

// File: hdl/control_unit.sv
module control_unit import cu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  opcode_t    op,       // From the instruction register
  input  logic       ra,       // Register select bit of the instruction
  input  logic       start,
  input  logic       n,
  input  logic       z,
  input  logic       v,
  input  logic       inp_ack,
  input  logic       out_ack,
  input  logic       ack_alu,  // ALU operation complete
  output logic       finish,
  output ctrl_word_t c
);

  instr_class_t iclass;
  ctrl_idx_t    alu_idx;
  logic         branch_taken;
  state_t       state;

  instr_decoder u_instr_decoder (
    .op           (op),
    .n            (n),
    .z            (z),
    .v            (v),
    .iclass       (iclass),
    .alu_idx      (alu_idx),
    .branch_taken (branch_taken)
  );

  cu_sequencer u_cu_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .inp_ack      (inp_ack),
    .out_ack      (out_ack),
    .ack_alu      (ack_alu),
    .iclass       (iclass),
    .branch_taken (branch_taken),
    .state        (state)
  );

  ctrl_encoder u_ctrl_encoder (
    .state   (state),
    .iclass  (iclass),
    .ra      (ra),
    .alu_idx (alu_idx),
    .finish  (finish),
    .c       (c)
  );

endmodule

// File: hdl/ctrl_encoder.sv
module ctrl_encoder import cu_pkg::*; (
  input  state_t       state,
  input  instr_class_t iclass,
  input  logic         ra,
  input  ctrl_idx_t    alu_idx,
  output logic         finish,
  output ctrl_word_t   c
);

  ctrl_idx_t sel;      // Active strobe in this state
  logic      sel_vld;  // Low in idle and in the waits

  always_comb begin
    sel     = C_START;
    sel_vld = 1'b1;
    case (state)
      ST_START:    sel = C_START;
      ST_FETCH:    sel = C_FETCH;
      ST_DECODE:   sel = C_DECODE;
      ST_ALU_DONE: sel = C_ALU_DONE;
      ST_STEP1: begin
        case (iclass)
          CL_LDR, CL_LDA_IMM:     sel = C_LD_ADDR;
          CL_LDA_OFF, CL_STA_OFF: sel = ra ? C_OFF_REG1 : C_OFF_REG0;
          CL_STR, CL_STA_IMM:     sel = C_ST_ADDR;
          CL_PSH, CL_JMP:         sel = C_PSH_SP;  // JMP saves the return PC first
          CL_POP, CL_RET:         sel = C_POP_SP;
          CL_IN:                  sel = C_IN_REQ;
          CL_OUT:                 sel = C_OUT_REQ;
          CL_BRANCH:              sel = C_PC_LOAD;
          CL_ALU_REG:             sel = alu_idx;
          CL_NOT_REG:             sel = C_NOT;
          CL_ALU_MEM, CL_NOT_MEM: sel = C_MEM_FETCH;
          CL_CMP:                 sel = C_CMP;
          CL_TST:                 sel = C_TST;
          CL_MOV_REG:             sel = C_MOV_REG;
          CL_MOV_IMM:             sel = C_MOV_IMM;
          default:                sel_vld = 1'b0;
        endcase
      end
      ST_STEP2: begin
        case (iclass)
          CL_LDR:                 sel = ra ? C_LD_REG1 : C_LD_REG0;
          CL_LDA_IMM:             sel = C_LD_ACC;
          CL_LDA_OFF, CL_STA_OFF: sel = C_OFF_ADD;
          CL_STR:                 sel = ra ? C_ST_REG1 : C_ST_REG0;
          CL_STA_IMM:             sel = C_ST_ACC;
          CL_PSH, CL_JMP:         sel = C_PSH_WR;
          CL_POP, CL_RET:         sel = C_POP_RD;
          CL_IN:                  sel = C_IN_WB;
          CL_ALU_REG:             sel = C_ALU_GO;
          CL_ALU_MEM:             sel = alu_idx;
          CL_NOT_MEM:             sel = C_NOT_MEM;
          CL_CMP, CL_TST:         sel = C_FLAG_GO;
          default:                sel_vld = 1'b0;
        endcase
      end
      ST_STEP3: begin
        case (iclass)
          CL_LDA_OFF: sel = C_LDA_EA;
          CL_STA_OFF: sel = C_STA_EA;
          CL_PSH:     sel = C_PSH_DONE;
          CL_POP:     sel = C_POP_WB;
          CL_JMP:     sel = C_JMP_TGT;
          CL_RET:     sel = C_RET_PC;
          CL_ALU_MEM: sel = C_ALU_GO;
          default:    sel_vld = 1'b0;
        endcase
      end
      ST_STEP4: begin
        case (iclass)
          CL_LDA_OFF: sel = C_LD_ACC;
          CL_STA_OFF: sel = C_ST_ACC;
          CL_JMP:     sel = C_PC_LOAD;
          default:    sel_vld = 1'b0;
        endcase
      end
      default: sel_vld = 1'b0;  // Idle and acknowledge waits
    endcase
  end

  always_comb begin
    c = '0;
    if (sel_vld) begin
      c[sel] = 1'b1;
    end
  end

  assign finish = (state == ST_IDLE);

endmodule

// File: hdl/cu_pkg.sv
package cu_pkg;

  localparam int OPCODE_W = 6;
  localparam int CTRL_W   = 58;

  typedef logic [OPCODE_W-1:0]        opcode_t;
  typedef logic [CTRL_W-1:0]          ctrl_word_t;  // One strobe per bit
  typedef logic [$clog2(CTRL_W)-1:0]  ctrl_idx_t;

  // Instruction set encodings
  localparam opcode_t OP_HLT     = 6'b000000, OP_LDR     = 6'b000001;
  localparam opcode_t OP_LDA_OFF = 6'b000010, OP_STR     = 6'b000011;
  localparam opcode_t OP_STA_OFF = 6'b000100, OP_LDA_IMM = 6'b000101;
  localparam opcode_t OP_STA_IMM = 6'b000110, OP_PSH     = 6'b000111;
  localparam opcode_t OP_POP     = 6'b001000, OP_IN      = 6'b001001;
  localparam opcode_t OP_OUT     = 6'b001010;
  localparam opcode_t OP_BEQ     = 6'b001011, OP_BNE     = 6'b001100;
  localparam opcode_t OP_BGT     = 6'b001101, OP_BLT     = 6'b001110;
  localparam opcode_t OP_BGE     = 6'b001111, OP_BLE     = 6'b010000;
  localparam opcode_t OP_BRA     = 6'b010001, OP_JMP     = 6'b010010;
  localparam opcode_t OP_RET     = 6'b010011;
  // Acc op= reg or immediate
  localparam opcode_t OP_ADD     = 6'b010100, OP_SUB     = 6'b010101;
  localparam opcode_t OP_MUL     = 6'b010110, OP_DIV     = 6'b010111;
  localparam opcode_t OP_MOD     = 6'b011000, OP_AND     = 6'b011001;
  localparam opcode_t OP_OR      = 6'b011010, OP_XOR     = 6'b011011;
  localparam opcode_t OP_NOT     = 6'b011100;
  // Acc op= mem[address]
  localparam opcode_t OP_ADD_MEM = 6'b011101, OP_SUB_MEM = 6'b011110;
  localparam opcode_t OP_MUL_MEM = 6'b011111, OP_DIV_MEM = 6'b100000;
  localparam opcode_t OP_MOD_MEM = 6'b100001, OP_AND_MEM = 6'b100010;
  localparam opcode_t OP_OR_MEM  = 6'b100011, OP_XOR_MEM = 6'b100100;
  localparam opcode_t OP_NOT_MEM = 6'b100101;
  localparam opcode_t OP_LSR     = 6'b100110, OP_LSL     = 6'b100111;
  localparam opcode_t OP_RSR     = 6'b101000, OP_RSL     = 6'b101001;
  localparam opcode_t OP_CMP     = 6'b101010, OP_TST     = 6'b101011;
  localparam opcode_t OP_MOV_IMM = 6'b101100, OP_MOV_REG = 6'b101101;

  // Control word bit positions
  localparam ctrl_idx_t C_START    = 6'd0,  C_FETCH    = 6'd1,  C_DECODE   = 6'd2;
  localparam ctrl_idx_t C_LD_ADDR  = 6'd3,  C_LD_REG0  = 6'd4,  C_LD_REG1  = 6'd5;
  localparam ctrl_idx_t C_OFF_REG0 = 6'd6,  C_OFF_REG1 = 6'd7,  C_OFF_ADD  = 6'd8;
  localparam ctrl_idx_t C_LDA_EA   = 6'd9,  C_LD_ACC   = 6'd10;
  localparam ctrl_idx_t C_ST_ADDR  = 6'd11, C_ST_REG0  = 6'd12, C_ST_REG1  = 6'd13;
  localparam ctrl_idx_t C_STA_EA   = 6'd14, C_ST_ACC   = 6'd15;
  localparam ctrl_idx_t C_PSH_SP   = 6'd16, C_PSH_WR   = 6'd17, C_PSH_DONE = 6'd18;
  localparam ctrl_idx_t C_POP_SP   = 6'd19, C_POP_RD   = 6'd20, C_POP_WB   = 6'd21;
  localparam ctrl_idx_t C_IN_REQ   = 6'd22, C_IN_WB    = 6'd23, C_OUT_REQ  = 6'd24;
  localparam ctrl_idx_t C_PC_LOAD  = 6'd25, C_ADD      = 6'd26;
  localparam ctrl_idx_t C_JMP_TGT  = 6'd27, C_RET_PC   = 6'd28;
  localparam ctrl_idx_t C_SUB      = 6'd29, C_MUL      = 6'd30, C_DIV      = 6'd31;
  localparam ctrl_idx_t C_MOD      = 6'd32, C_AND      = 6'd33, C_OR       = 6'd34;
  localparam ctrl_idx_t C_XOR      = 6'd35, C_NOT      = 6'd36;
  localparam ctrl_idx_t C_ADD_MEM  = 6'd37, C_SUB_MEM  = 6'd38, C_MUL_MEM  = 6'd39;
  localparam ctrl_idx_t C_DIV_MEM  = 6'd40, C_MOD_MEM  = 6'd41, C_AND_MEM  = 6'd42;
  localparam ctrl_idx_t C_OR_MEM   = 6'd43, C_XOR_MEM  = 6'd44, C_NOT_MEM  = 6'd45;
  localparam ctrl_idx_t C_LSR      = 6'd46, C_LSL      = 6'd47;
  localparam ctrl_idx_t C_RSR      = 6'd48, C_RSL      = 6'd49;
  localparam ctrl_idx_t C_ALU_GO   = 6'd50, C_ALU_DONE = 6'd51;
  localparam ctrl_idx_t C_CMP      = 6'd52, C_FLAG_GO  = 6'd53, C_TST      = 6'd54;
  localparam ctrl_idx_t C_MOV_REG  = 6'd55, C_MOV_IMM  = 6'd56;
  localparam ctrl_idx_t C_MEM_FETCH = 6'd57;  // Operand read ahead of a memory ALU op

  typedef enum logic [4:0] {
    CL_HLT, CL_LDR, CL_LDA_OFF, CL_LDA_IMM, CL_STR, CL_STA_OFF, CL_STA_IMM,
    CL_PSH, CL_POP, CL_IN, CL_OUT, CL_BRANCH, CL_JMP, CL_RET,
    CL_ALU_REG, CL_NOT_REG, CL_ALU_MEM, CL_NOT_MEM,
    CL_CMP, CL_TST, CL_MOV_REG, CL_MOV_IMM,
    CL_NONE  // Opcodes without a sequence
  } instr_class_t;

  typedef enum logic [3:0] {
    ST_IDLE, ST_START, ST_FETCH, ST_DECODE,
    ST_STEP1, ST_STEP2, ST_STEP3, ST_STEP4,
    ST_WAIT_ALU, ST_ALU_DONE, ST_WAIT_INP, ST_WAIT_OUT
  } state_t;

endpackage

// File: hdl/cu_sequencer.sv
module cu_sequencer import cu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  logic         inp_ack,
  input  logic         out_ack,
  input  logic         ack_alu,
  input  instr_class_t iclass,
  input  logic         branch_taken,
  output state_t       state
);

  state_t state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_START;
        end
      end
      ST_START:  state_nxt = ST_FETCH;
      ST_FETCH:  state_nxt = ST_DECODE;
      ST_DECODE: begin
        case (iclass)
          CL_HLT:    state_nxt = ST_IDLE;
          CL_NONE:   state_nxt = ST_FETCH;
          CL_BRANCH: state_nxt = branch_taken ? ST_STEP1 : ST_FETCH;
          default:   state_nxt = ST_STEP1;
        endcase
      end

      ST_STEP1: begin
        case (iclass)
          CL_LDR, CL_LDA_OFF, CL_LDA_IMM,
          CL_STR, CL_STA_OFF, CL_STA_IMM,
          CL_PSH, CL_POP, CL_JMP, CL_RET,
          CL_ALU_REG, CL_ALU_MEM, CL_NOT_MEM,
          CL_CMP, CL_TST:
            state_nxt = ST_STEP2;
          CL_IN:      state_nxt = ST_WAIT_INP;
          CL_OUT:     state_nxt = ST_WAIT_OUT;
          CL_NOT_REG: state_nxt = ST_WAIT_ALU;  // Single setup step
          default:    state_nxt = ST_FETCH;     // Branch, MOV
        endcase
      end

      ST_STEP2: begin
        case (iclass)
          CL_LDA_OFF, CL_STA_OFF, CL_ALU_REG,
          CL_NOT_MEM, CL_CMP, CL_TST:
            state_nxt = ST_WAIT_ALU;
          CL_PSH, CL_POP, CL_JMP, CL_RET, CL_ALU_MEM:
            state_nxt = ST_STEP3;
          default:
            state_nxt = ST_FETCH;
        endcase
      end

      ST_STEP3: begin
        case (iclass)
          CL_LDA_OFF, CL_STA_OFF, CL_JMP:
            state_nxt = ST_STEP4;
          CL_ALU_MEM:
            state_nxt = ST_WAIT_ALU;
          default:
            state_nxt = ST_FETCH;
        endcase
      end

      ST_STEP4: state_nxt = ST_FETCH;

      // Hold until the ALU reports done
      ST_WAIT_ALU: begin
        if (ack_alu) begin
          case (iclass)
            CL_LDA_OFF, CL_STA_OFF: state_nxt = ST_STEP3;  // Address ready
            CL_CMP, CL_TST:         state_nxt = ST_FETCH;  // Only flags updated
            default:                state_nxt = ST_ALU_DONE;
          endcase
        end
      end

      ST_ALU_DONE: state_nxt = ST_FETCH;

      ST_WAIT_INP: begin
        if (inp_ack) begin
          state_nxt = ST_STEP2;
        end
      end

      ST_WAIT_OUT: begin
        if (out_ack) begin
          state_nxt = ST_FETCH;
        end
      end

      default: state_nxt = ST_IDLE;
    endcase
  end

endmodule

// File: hdl/instr_decoder.sv
module instr_decoder import cu_pkg::*; (
  input  opcode_t      op,
  input  logic         n,
  input  logic         z,
  input  logic         v,
  output instr_class_t iclass,
  output ctrl_idx_t    alu_idx,
  output logic         branch_taken
);

  logic nv_eq;  // Signed compare result, no overflow mismatch

  assign nv_eq = (n == v);

  always_comb begin
    case (op)
      OP_HLT:     iclass = CL_HLT;
      OP_LDR:     iclass = CL_LDR;
      OP_LDA_OFF: iclass = CL_LDA_OFF;
      OP_LDA_IMM: iclass = CL_LDA_IMM;
      OP_STR:     iclass = CL_STR;
      OP_STA_OFF: iclass = CL_STA_OFF;
      OP_STA_IMM: iclass = CL_STA_IMM;
      OP_PSH:     iclass = CL_PSH;
      OP_POP:     iclass = CL_POP;
      OP_IN:      iclass = CL_IN;
      OP_OUT:     iclass = CL_OUT;
      OP_BEQ, OP_BNE, OP_BGT, OP_BLT, OP_BGE, OP_BLE, OP_BRA:
        iclass = CL_BRANCH;
      OP_JMP:     iclass = CL_JMP;
      OP_RET:     iclass = CL_RET;
      OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD, OP_AND, OP_OR, OP_XOR,
      OP_LSR, OP_LSL, OP_RSR, OP_RSL:
        iclass = CL_ALU_REG;  // Shifts share the register path
      OP_NOT:     iclass = CL_NOT_REG;
      OP_ADD_MEM, OP_SUB_MEM, OP_MUL_MEM, OP_DIV_MEM,
      OP_MOD_MEM, OP_AND_MEM, OP_OR_MEM, OP_XOR_MEM:
        iclass = CL_ALU_MEM;
      OP_NOT_MEM: iclass = CL_NOT_MEM;
      OP_CMP:     iclass = CL_CMP;
      OP_TST:     iclass = CL_TST;
      OP_MOV_REG: iclass = CL_MOV_REG;
      OP_MOV_IMM: iclass = CL_MOV_IMM;
      default:    iclass = CL_NONE;  // Dropped macro opcodes fall back to fetch
    endcase
  end

  // Operation select strobe for the ALU step
  always_comb begin
    case (op)
      OP_ADD:     alu_idx = C_ADD;
      OP_SUB:     alu_idx = C_SUB;
      OP_MUL:     alu_idx = C_MUL;
      OP_DIV:     alu_idx = C_DIV;
      OP_MOD:     alu_idx = C_MOD;
      OP_AND:     alu_idx = C_AND;
      OP_OR:      alu_idx = C_OR;
      OP_XOR:     alu_idx = C_XOR;
      OP_LSR:     alu_idx = C_LSR;
      OP_LSL:     alu_idx = C_LSL;
      OP_RSR:     alu_idx = C_RSR;
      OP_RSL:     alu_idx = C_RSL;
      OP_ADD_MEM: alu_idx = C_ADD_MEM;
      OP_SUB_MEM: alu_idx = C_SUB_MEM;
      OP_MUL_MEM: alu_idx = C_MUL_MEM;
      OP_DIV_MEM: alu_idx = C_DIV_MEM;
      OP_MOD_MEM: alu_idx = C_MOD_MEM;
      OP_AND_MEM: alu_idx = C_AND_MEM;
      OP_OR_MEM:  alu_idx = C_OR_MEM;
      OP_XOR_MEM: alu_idx = C_XOR_MEM;
      default:    alu_idx = '0;  // Not looked at outside ALU classes
    endcase
  end

  always_comb begin
    case (op)
      OP_BEQ:  branch_taken = z;
      OP_BNE:  branch_taken = !z;
      OP_BGT:  branch_taken = !z && nv_eq;
      OP_BLT:  branch_taken = !nv_eq;
      OP_BGE:  branch_taken = nv_eq;
      OP_BLE:  branch_taken = z || !nv_eq;
      OP_BRA:  branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: tb/control_unit_chk.sv
module control_unit_chk import cu_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       finish,
  input ctrl_word_t c
);
  timeunit 1ns;
  timeprecision 100ps;

  // One strobe at most
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(c))
    else $error("control word has more than one bit set");

  assert property (@(posedge clk) disable iff (!rst_n) finish |-> (c == '0))
    else $error("control word active while finish is high");

  // Start strobe only right after idle
  assert property (@(posedge clk) disable iff (!rst_n) c[0] |-> $past(finish))
    else $error("start strobe without a preceding idle cycle");

  assert property (@(posedge clk) disable iff (!rst_n) c[2] |=> !c[2])
    else $error("decode state held for more than one cycle");

endmodule

// File: tb/cu_trace.txt
# op(hex) ra n z v ack_delay steps, then six expected control-bit indices
# Unused index columns are 0; each sequence begins with fetch (1) and decode (2)
00 0 0 0 0 0 2 1 2 0 0 0 0
01 0 0 0 0 0 4 1 2 3 4 0 0
01 1 0 0 0 0 4 1 2 3 5 0 0
02 0 0 0 0 0 6 1 2 6 8 9 10
02 1 0 0 0 2 6 1 2 7 8 9 10
05 0 0 0 0 0 4 1 2 3 10 0 0
03 0 0 0 0 0 4 1 2 11 12 0 0
03 1 0 0 0 0 4 1 2 11 13 0 0
04 0 0 0 0 1 6 1 2 6 8 14 15
04 1 0 0 0 0 6 1 2 7 8 14 15
06 0 0 0 0 0 4 1 2 11 15 0 0
2d 0 0 0 0 0 3 1 2 55 0 0 0
2c 1 0 0 0 0 3 1 2 56 0 0 0
0b 0 0 1 0 0 3 1 2 25 0 0 0
0b 0 0 0 0 0 2 1 2 0 0 0 0
0c 0 0 0 0 0 3 1 2 25 0 0 0
0c 0 0 1 0 0 2 1 2 0 0 0 0
0d 0 0 0 0 0 3 1 2 25 0 0 0
0d 0 1 0 0 0 2 1 2 0 0 0 0
0e 0 1 0 0 0 3 1 2 25 0 0 0
0e 0 1 0 1 0 2 1 2 0 0 0 0
0f 0 1 0 1 0 3 1 2 25 0 0 0
0f 0 1 0 0 0 2 1 2 0 0 0 0
10 0 0 1 0 0 3 1 2 25 0 0 0
10 0 0 0 0 0 2 1 2 0 0 0 0
11 0 0 0 0 0 3 1 2 25 0 0 0
14 0 0 0 0 0 5 1 2 26 50 51 0
16 0 0 0 0 3 5 1 2 30 50 51 0
26 0 0 0 0 0 5 1 2 46 50 51 0
1c 0 0 0 0 3 4 1 2 36 51 0 0
1d 0 0 0 0 0 6 1 2 57 37 50 51
24 0 0 0 0 3 6 1 2 57 44 50 51
25 0 0 0 0 0 5 1 2 57 45 51 0
2a 0 0 0 0 3 4 1 2 52 53 0 0
2b 0 0 0 0 0 4 1 2 54 53 0 0
07 0 0 0 0 0 5 1 2 16 17 18 0
08 0 0 0 0 0 5 1 2 19 20 21 0
12 0 0 0 0 0 6 1 2 16 17 27 25
13 0 0 0 0 0 5 1 2 19 20 28 0
09 0 0 0 0 2 4 1 2 22 23 0 0
0a 0 0 0 0 3 3 1 2 24 0 0 0
2e 0 0 0 0 0 2 1 2 0 0 0 0
00 0 0 0 0 0 2 1 2 0 0 0 0

// File: tb/tb_control_unit.sv
module tb_control_unit import cu_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LINES = 64;
  localparam int MAX_STEPS = 6;

  logic       clk = 1'b0;
  logic       rst_n;
  opcode_t    op;
  logic       ra, start, n, z, v;
  logic       inp_ack, out_ack, ack_alu;
  logic       finish;
  ctrl_word_t c;

  int t_op    [MAX_LINES];
  int t_ra    [MAX_LINES];
  int t_n     [MAX_LINES];
  int t_z     [MAX_LINES];
  int t_v     [MAX_LINES];
  int t_d     [MAX_LINES];
  int t_steps [MAX_LINES];
  int t_exp   [MAX_LINES][MAX_STEPS];
  int num_lines;
  int errors;
  int cycles;
  int cycle_limit;
  int wait_cnt;   // Cycles seen in the current acknowledge wait
  int cur_d;      // Acknowledge delay of the running instruction
  int last_idx;   // Strobe that opened the current wait

  control_unit u_control_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (op),
    .ra      (ra),
    .start   (start),
    .n       (n),
    .z       (z),
    .v       (v),
    .inp_ack (inp_ack),
    .out_ack (out_ack),
    .ack_alu (ack_alu),
    .finish  (finish),
    .c       (c)
  );

  bind control_unit control_unit_chk u_control_unit_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .finish (finish),
    .c      (c)
  );

  always #5 clk = ~clk;

  // Run limit, armed once the trace is loaded
  always @(posedge clk) begin
    if (rst_n) begin
      cycles = cycles + 1;
    end
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the control unit stopped stepping after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic int bit_index(input ctrl_word_t w);
    for (int i = 0; i < CTRL_W; i++) begin
      if (w[i]) return i;
    end
    return -1;
  endfunction

  // Advance to the next cycle with a control strobe, serving acknowledge waits
  task automatic next_step(output int idx);
    bit found;
    found = 1'b0;
    while (!found) begin
      @(negedge clk);
      start = 1'b0;
      if (c != '0) begin
        {inp_ack, out_ack, ack_alu} = 3'b000;
        if (wait_cnt != 0) begin
          check_value("ack_wait", wait_cnt, cur_d + 1);  // d low cycles, then one high
        end
        wait_cnt = 0;
        idx      = bit_index(c);
        last_idx = idx;
        found    = 1'b1;
      end else if (finish) begin
        idx   = -1;  // Fell back to idle
        found = 1'b1;
      end else begin
        if (wait_cnt == cur_d) begin
          // Only the acknowledge that belongs to this wait
          if (last_idx == C_IN_REQ) begin
            inp_ack = 1'b1;
          end else if (last_idx == C_OUT_REQ) begin
            out_ack = 1'b1;
          end else begin
            ack_alu = 1'b1;
          end
        end else begin
          {inp_ack, out_ack, ack_alu} = 3'b000;
        end
        wait_cnt++;
      end
    end
  endtask

  initial begin
    int    fd;
    int    cnt;
    int    idx;
    int    f[13];
    string line;

    rst_n = 1'b0;
    op    = '0;
    {ra, start, n, z, v}        = '0;
    {inp_ack, out_ack, ack_alu} = '0;
    errors = 0;
    cycles = 0;
    cycle_limit = 0;
    num_lines = 0;
    wait_cnt = 0;
    cur_d = 0;
    last_idx = -1;

    fd = $fopen("tb/cu_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/cu_trace.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end
    while (!$feof(fd) && num_lines < MAX_LINES) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
      if (cnt == 13) begin
        t_op[num_lines]    = f[0];
        t_ra[num_lines]    = f[1];
        t_n[num_lines]     = f[2];
        t_z[num_lines]     = f[3];
        t_v[num_lines]     = f[4];
        t_d[num_lines]     = f[5];
        t_steps[num_lines] = f[6];
        for (int j = 0; j < MAX_STEPS; j++) t_exp[num_lines][j] = f[7+j];
        num_lines++;
      end
    end
    $fclose(fd);
    if (num_lines == 0) begin
      $display("The trace file holds no instruction lines");
      errors++;
    end

    for (int k = 0; k < num_lines; k++) begin
      cycle_limit += t_steps[k] + t_d[k] + 6;
    end
    cycle_limit += 50;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("finish", int'(finish), 1);
    check_value("c", bit_index(c), -1);

    for (int k = 0; k < num_lines; k++) begin
      if (finish) begin
        start = 1'b1;  // Leave idle
        next_step(idx);
        check_value("c", idx, 0);
      end
      next_step(idx);
      // Fetch cycle, load the instruction fields
      op    = t_op[k][5:0];
      ra    = t_ra[k][0];
      n     = t_n[k][0];
      z     = t_z[k][0];
      v     = t_v[k][0];
      cur_d = t_d[k];
      check_value("c", idx, t_exp[k][0]);
      for (int j = 1; j < t_steps[k]; j++) begin
        next_step(idx);
        check_value("c", idx, t_exp[k][j]);
      end
      if (opcode_t'(t_op[k]) == OP_HLT) begin
        @(negedge clk);
        check_value("finish", int'(finish), 1);
        check_value("c", bit_index(c), -1);
      end
    end

    $display("Run complete: %0d errors over %0d trace lines", errors, num_lines);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
